// ==== logic/vchess_defines.svh ====
`ifndef VCHESS_DEFINES_SVH
`define VCHESS_DEFINES_SVH

// Board geometry
`define SIDE_WIDTH 32
`define BOARD_WIDTH 256

`define EVAL_WIDTH 16
`define HALF_MOVE_WIDTH 8
`define REG_INDEX_WIDTH 14

// Centipawns
`define VAL_PAWN 100
`define VAL_KNIGHT 320
`define VAL_BISHOP 330
`define VAL_ROOK 500
`define VAL_QUEEN 900

// Host-written registers, index = byte address / 4
`define REG_CTRL 0
`define REG_FLAGS 2
`define REG_HALF_MOVE 3
`define REG_BOARD0 8

// Analysis results
`define REG_WATK_LO 128
`define REG_BATK_LO 130
`define REG_CHECK 132
`define REG_EVAL 134
`define REG_SNAP0 172

`endif

// ==== logic/vchess_pkg.sv ====
`include "vchess_defines.svh"

package vchess_pkg;

   typedef enum logic [2:0] {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_kind_t;

   typedef struct packed {
      logic        black;
      piece_kind_t kind;
   } piece_t;

   typedef piece_t [7:0] board_row_t;     // Column 0 in low nibble
   typedef board_row_t [7:0] board_t;     // Row 0 is rank 1

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } pos_flags_t;

   // One register word, seen as a board row or as the flags word
   typedef union packed {
      board_row_t row;
      struct packed {
         logic [`SIDE_WIDTH-$bits(pos_flags_t)-1:0] pad;
         pos_flags_t                                 flags;
      } flag_word;
   } reg_word_u;

   typedef struct packed {
      board_t                       board;
      pos_flags_t                   flags;
      logic [`HALF_MOVE_WIDTH-1:0]  half_move;
   } position_t;

   typedef struct packed {
      logic [`REG_INDEX_WIDTH-1:0] index;
      reg_word_u                   data;
   } wr_req_t;

   typedef struct packed {
      logic [63:0]                    white_attacks;
      logic [63:0]                    black_attacks;
      logic                           white_in_check;
      logic                           black_in_check;
      logic signed [`EVAL_WIDTH-1:0]  eval;
      board_t                         board;
   } analysis_t;

endpackage

// ==== logic/axi4lite_write.sv ====
`include "vchess_defines.svh"

module axi4lite_write
  (
   input  logic                clk,
   input  logic                rst,

   input  logic [39:0]         axi_awaddr,
   input  logic                axi_awvalid,
   output logic                axi_awready,
   input  logic [31:0]         axi_wdata,
   input  logic                axi_wvalid,
   output logic                axi_wready,
   output logic                axi_bvalid,
   output logic [1:0]          axi_bresp,
   input  logic                axi_bready,

   output vchess_pkg::wr_req_t wr,
   output logic                wr_valid
   );

   logic aw_held;
   logic w_held;

   assign axi_awready = !aw_held;
   assign axi_wready = !w_held;
   assign axi_bresp = 2'b00;             // OKAY

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         aw_held <= 1'b0;
         w_held <= 1'b0;
         wr_valid <= 1'b0;
         axi_bvalid <= 1'b0;
      end
      else
      begin
         wr_valid <= 1'b0;
         if (axi_awvalid && axi_awready)
            aw_held <= 1'b1;
         if (axi_wvalid && axi_wready)
            w_held <= 1'b1;
         if (aw_held && w_held && !axi_bvalid)
         begin
            wr_valid <= 1'b1;            // Single strobe per transaction
            axi_bvalid <= 1'b1;
         end
         if (axi_bvalid && axi_bready)
         begin
            aw_held <= 1'b0;             // Reopen both channels
            w_held <= 1'b0;
            axi_bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (axi_awvalid && axi_awready)
         wr.index <= axi_awaddr[`REG_INDEX_WIDTH+1:2];
      if (axi_wvalid && axi_wready)
         wr.data <= axi_wdata;
   end

endmodule

// ==== logic/control.sv ====
`include "vchess_defines.svh"

module control
   import vchess_pkg::*;
  (
   input  logic        clk,
   input  logic        rst,

   input  wr_req_t     wr,
   input  logic        wr_valid,

   input  logic [39:0] axi_araddr,
   input  logic        axi_arvalid,
   input  logic        axi_rready,
   output logic [31:0] axi_rdata,
   output logic        axi_rvalid,

   output logic        start,
   output position_t   position,
   output logic        soft_reset,

   input  logic        done,
   input  analysis_t   result
   );

   position_t                   pos_q;            // Host-written position
   analysis_t                   res_q;
   logic                        analysis_valid;
   logic                        ctrl_wr;
   logic                        start_req;
   logic [`REG_INDEX_WIDTH-1:0] rd_index;
   logic [2:0]                  board_row;
   logic [2:0]                  snap_row;
   reg_word_u                   flags_word;
   logic [`SIDE_WIDTH-1:0]      rd_word;

   assign ctrl_wr = wr_valid && (wr.index == `REG_CTRL);
   assign start_req = ctrl_wr && wr.data[0];

   always_ff @(posedge clk)
   begin
      if (wr_valid)
      begin
         if (wr.index == `REG_FLAGS)
            pos_q.flags <= wr.data.flag_word.flags;
         if (wr.index == `REG_HALF_MOVE)
            pos_q.half_move <= wr.data[`HALF_MOVE_WIDTH-1:0];
         if (wr.index >= `REG_BOARD0 && wr.index < `REG_BOARD0 + 8)
            pos_q.board[wr.index[2:0]] <= wr.data.row;
      end
      if (start_req)
         position <= pos_q;                         // Snapshot travels with start
      if (done)
         res_q <= result;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         soft_reset <= 1'b0;
      else if (ctrl_wr)
         soft_reset <= wr.data[31];
   end

   always_ff @(posedge clk)
   begin
      if (rst || soft_reset)
      begin
         start <= 1'b0;
         analysis_valid <= 1'b0;
      end
      else
      begin
         start <= start_req && !wr.data[31];
         if (done)
            analysis_valid <= 1'b1;
      end
   end

   assign rd_index = axi_araddr[`REG_INDEX_WIDTH+1:2];
   assign board_row = 3'(rd_index - `REG_BOARD0);
   assign snap_row = 3'(rd_index - `REG_SNAP0);

   always_comb
   begin
      flags_word = '0;
      flags_word.flag_word.flags = pos_q.flags;
   end

   always_comb
   begin
      rd_word = '0;
      case (rd_index) inside
         `REG_CTRL:
         begin
            rd_word[2] = analysis_valid;
            rd_word[31] = soft_reset;
         end
         `REG_FLAGS:
            rd_word = flags_word;
         `REG_HALF_MOVE:
            rd_word[`HALF_MOVE_WIDTH-1:0] = pos_q.half_move;
         [`REG_BOARD0:`REG_BOARD0+7]:
            rd_word = pos_q.board[board_row];
         `REG_WATK_LO:
            rd_word = res_q.white_attacks[31:0];
         `REG_WATK_LO + 1:
            rd_word = res_q.white_attacks[63:32];
         `REG_BATK_LO:
            rd_word = res_q.black_attacks[31:0];
         `REG_BATK_LO + 1:
            rd_word = res_q.black_attacks[63:32];
         `REG_CHECK:
            rd_word[1:0] = {res_q.black_in_check, res_q.white_in_check};
         `REG_EVAL:
            rd_word = {{(`SIDE_WIDTH-`EVAL_WIDTH){res_q.eval[`EVAL_WIDTH-1]}}, res_q.eval};
         [`REG_SNAP0:`REG_SNAP0+7]:
            rd_word = res_q.board[snap_row];
         default:
            rd_word = '0;                           // Unmapped reads 0
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         axi_rvalid <= 1'b0;
      else if (axi_arvalid)
         axi_rvalid <= 1'b1;
      else if (axi_rready)
         axi_rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (axi_arvalid)
         axi_rdata <= rd_word;
   end

endmodule

// ==== logic/material_eval.sv ====
`include "vchess_defines.svh"

module material_eval
   import vchess_pkg::*;
  (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           start,
   input  position_t                      position,
   output logic                           eval_valid,
   output position_t                      eval_position,
   output logic signed [`EVAL_WIDTH-1:0]  eval
   );

   logic signed [`EVAL_WIDTH-1:0] sum;

   function automatic logic signed [`EVAL_WIDTH-1:0] piece_value(piece_t p);
      logic signed [`EVAL_WIDTH-1:0] v;
      case (p.kind)
         PAWN:        v = `VAL_PAWN;
         KNIGHT:      v = `VAL_KNIGHT;
         BISHOP:      v = `VAL_BISHOP;
         ROOK:        v = `VAL_ROOK;
         QUEEN:       v = `VAL_QUEEN;
         EMPTY, KING: v = '0;               // King has no material value
         default:     v = '0;
      endcase
      return p.black ? -v : v;
   endfunction

   // White minus black over the whole board
   always_comb
   begin
      sum = '0;
      for (int r = 0; r < 8; r++)
         for (int c = 0; c < 8; c++)
            sum = sum + piece_value(position.board[r][c]);
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         eval_valid <= 1'b0;
      else
         eval_valid <= start;
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         eval_position <= position;
         eval <= sum;
      end
   end

endmodule

// ==== logic/attack_map.sv ====
`include "vchess_defines.svh"

module attack_map
   import vchess_pkg::*;
  (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           eval_valid,
   input  position_t                      eval_position,
   input  logic signed [`EVAL_WIDTH-1:0]  eval,
   output logic                           done,
   output analysis_t                      result
   );

   logic [63:0] white_atk;
   logic [63:0] black_atk;
   logic [63:0] white_king;
   logic [63:0] black_king;

   // Off-board targets give an empty mask, so nothing wraps across files
   function automatic logic [63:0] square_bit(int r, int c);
      logic [63:0] m;
      m = '0;
      if (r >= 0 && r < 8 && c >= 0 && c < 8)
         m[r * 8 + c] = 1'b1;
      return m;
   endfunction

   function automatic logic [63:0] piece_attacks(piece_t p, int r, int c);
      logic [63:0] m;
      int          fwd;
      m = '0;
      fwd = p.black ? -1 : 1;             // Pawns capture toward the enemy
      case (p.kind)
         PAWN:
            m = square_bit(r + fwd, c - 1) | square_bit(r + fwd, c + 1);
         KNIGHT:
            for (int dr = -2; dr <= 2; dr++)
               for (int dc = -2; dc <= 2; dc++)
                  if (dr * dr + dc * dc == 5)
                     m = m | square_bit(r + dr, c + dc);
         KING:
            for (int dr = -1; dr <= 1; dr++)
               for (int dc = -1; dc <= 1; dc++)
                  if (dr != 0 || dc != 0)
                     m = m | square_bit(r + dr, c + dc);
         default:
            m = '0;                       // Sliders not covered
      endcase
      return m;
   endfunction

   always_comb
   begin
      white_atk = '0;
      black_atk = '0;
      white_king = '0;
      black_king = '0;
      for (int r = 0; r < 8; r++)
         for (int c = 0; c < 8; c++)
         begin
            if (eval_position.board[r][c].black)
               black_atk = black_atk | piece_attacks(eval_position.board[r][c], r, c);
            else
               white_atk = white_atk | piece_attacks(eval_position.board[r][c], r, c);
            if (eval_position.board[r][c].kind == KING)
            begin
               if (eval_position.board[r][c].black)
                  black_king[r * 8 + c] = 1'b1;
               else
                  white_king[r * 8 + c] = 1'b1;
            end
         end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         done <= 1'b0;
      else
         done <= eval_valid;
   end

   always_ff @(posedge clk)
   begin
      if (eval_valid)
      begin
         result.white_attacks <= white_atk;
         result.black_attacks <= black_atk;
         result.white_in_check <= |(white_king & black_atk);
         result.black_in_check <= |(black_king & white_atk);
         result.eval <= eval;
         result.board <= eval_position.board;
      end
   end

endmodule

// ==== logic/vchess_top.sv ====
`include "vchess_defines.svh"

module vchess_top
   import vchess_pkg::*;
  (
   input  logic        clk,
   input  logic        rst,

   input  logic [39:0] ctrl0_axi_araddr,
   input  logic [2:0]  ctrl0_axi_arprot,
   input  logic        ctrl0_axi_arvalid,
   input  logic [39:0] ctrl0_axi_awaddr,
   input  logic [2:0]  ctrl0_axi_awprot,
   input  logic        ctrl0_axi_awvalid,
   input  logic        ctrl0_axi_bready,
   input  logic        ctrl0_axi_rready,
   input  logic [31:0] ctrl0_axi_wdata,
   input  logic [3:0]  ctrl0_axi_wstrb,
   input  logic        ctrl0_axi_wvalid,

   output logic        ctrl0_axi_arready,
   output logic        ctrl0_axi_awready,
   output logic [1:0]  ctrl0_axi_bresp,
   output logic        ctrl0_axi_bvalid,
   output logic [31:0] ctrl0_axi_rdata,
   output logic [1:0]  ctrl0_axi_rresp,
   output logic        ctrl0_axi_rvalid,
   output logic        ctrl0_axi_wready
   );

   wr_req_t                       wr;
   logic                          wr_valid;
   logic                          start;
   position_t                     position;
   logic                          soft_reset;
   logic                          eval_valid;
   position_t                     eval_position;
   logic signed [`EVAL_WIDTH-1:0] eval;
   logic                          done;
   analysis_t                     result;

   assign ctrl0_axi_arready = 1'b1;
   assign ctrl0_axi_rresp = 2'b00;

   axi4lite_write axi4lite_write_ctrl0
     (
      .clk         (clk),
      .rst         (rst),
      .axi_awaddr  (ctrl0_axi_awaddr),
      .axi_awvalid (ctrl0_axi_awvalid),
      .axi_awready (ctrl0_axi_awready),
      .axi_wdata   (ctrl0_axi_wdata),
      .axi_wvalid  (ctrl0_axi_wvalid),
      .axi_wready  (ctrl0_axi_wready),
      .axi_bvalid  (ctrl0_axi_bvalid),
      .axi_bresp   (ctrl0_axi_bresp),
      .axi_bready  (ctrl0_axi_bready),
      .wr          (wr),
      .wr_valid    (wr_valid)
      );

   control control
     (
      .clk         (clk),
      .rst         (rst),
      .wr          (wr),
      .wr_valid    (wr_valid),
      .axi_araddr  (ctrl0_axi_araddr),
      .axi_arvalid (ctrl0_axi_arvalid),
      .axi_rready  (ctrl0_axi_rready),
      .axi_rdata   (ctrl0_axi_rdata),
      .axi_rvalid  (ctrl0_axi_rvalid),
      .start       (start),
      .position    (position),
      .soft_reset  (soft_reset),
      .done        (done),
      .result      (result)
      );

   material_eval material_eval
     (
      .clk           (clk),
      .rst           (rst || soft_reset),
      .start         (start),
      .position      (position),
      .eval_valid    (eval_valid),
      .eval_position (eval_position),
      .eval          (eval)
      );

   attack_map attack_map
     (
      .clk           (clk),
      .rst           (rst || soft_reset),
      .eval_valid    (eval_valid),
      .eval_position (eval_position),
      .eval          (eval),
      .done          (done),
      .result        (result)
      );

endmodule

// ==== verif/vchess_tb.sv ====
`include "vchess_defines.svh"

module vchess_tb;

   localparam int WAIT_LIMIT = 50;           // Clock cycles per handshake
   localparam int POLL_LIMIT = 20;           // Status reads per analysis

   logic        clk;
   logic        rst;
   logic [39:0] axi_araddr;
   logic [2:0]  axi_arprot;
   logic        axi_arvalid;
   logic [39:0] axi_awaddr;
   logic [2:0]  axi_awprot;
   logic        axi_awvalid;
   logic        axi_bready;
   logic        axi_rready;
   logic [31:0] axi_wdata;
   logic [3:0]  axi_wstrb;
   logic        axi_wvalid;
   logic        axi_arready;
   logic        axi_awready;
   logic [1:0]  axi_bresp;
   logic        axi_bvalid;
   logic [31:0] axi_rdata;
   logic [1:0]  axi_rresp;
   logic        axi_rvalid;
   logic        axi_wready;

   int          checks;
   int          test_errors;
   int          total_errors;
   int          failed_tests;
   logic [255:0] boards [10];

   vchess_top uut
     (
      .clk               (clk),
      .rst               (rst),
      .ctrl0_axi_araddr  (axi_araddr),
      .ctrl0_axi_arprot  (axi_arprot),
      .ctrl0_axi_arvalid (axi_arvalid),
      .ctrl0_axi_awaddr  (axi_awaddr),
      .ctrl0_axi_awprot  (axi_awprot),
      .ctrl0_axi_awvalid (axi_awvalid),
      .ctrl0_axi_bready  (axi_bready),
      .ctrl0_axi_rready  (axi_rready),
      .ctrl0_axi_wdata   (axi_wdata),
      .ctrl0_axi_wstrb   (axi_wstrb),
      .ctrl0_axi_wvalid  (axi_wvalid),
      .ctrl0_axi_arready (axi_arready),
      .ctrl0_axi_awready (axi_awready),
      .ctrl0_axi_bresp   (axi_bresp),
      .ctrl0_axi_bvalid  (axi_bvalid),
      .ctrl0_axi_rdata   (axi_rdata),
      .ctrl0_axi_rresp   (axi_rresp),
      .ctrl0_axi_rvalid  (axi_rvalid),
      .ctrl0_axi_wready  (axi_wready)
      );

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("timeout: %s (time %0t)", why, $time);
      $display("test failed");
      $finish;
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic end_test(input string name);
      $display("%-18s %s (%0d errors)", name, test_errors == 0 ? "ok" : "FAIL", test_errors);
      total_errors += test_errors;
      if (test_errors != 0)
         failed_tests++;
      test_errors = 0;
   endtask

   // Handshakes are judged on values seen at the rising edge
   task automatic axi_write(input int index, input logic [31:0] data, input int hold_b);
      int   cycles;
      logic aw_done;
      logic w_done;
      @(posedge clk);
      axi_awaddr <= 40'(index) << 2;
      axi_awvalid <= 1'b1;
      axi_wdata <= data;
      axi_wvalid <= 1'b1;
      aw_done = 1'b0;
      w_done = 1'b0;
      cycles = 0;
      while (!aw_done || !w_done)
      begin
         @(posedge clk);
         if (!aw_done && axi_awready)
         begin
            aw_done = 1'b1;
            axi_awvalid <= 1'b0;
         end
         if (!w_done && axi_wready)
         begin
            w_done = 1'b1;
            axi_wvalid <= 1'b0;
         end
         cycles++;
         if (cycles > WAIT_LIMIT)
            abort_run("awready or wready never accepted the write");
      end
      cycles = 0;
      while (!axi_bvalid)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            abort_run("bvalid never rose after a write");
      end
      check_word("write response code", 32'(axi_bresp), 32'd0);
      repeat (hold_b)
      begin
         @(posedge clk);
         check_word("bvalid with bready low", 32'(axi_bvalid), 32'd1);
         check_word("awready with response pending", 32'(axi_awready), 32'd0);
      end
      @(posedge clk);
      axi_bready <= 1'b1;
      @(posedge clk);
      axi_bready <= 1'b0;
   endtask

   task automatic axi_read(input int index, output logic [31:0] data);
      int cycles;
      @(posedge clk);
      axi_araddr <= 40'(index) << 2;
      axi_arvalid <= 1'b1;
      @(posedge clk);                        // arready is always high
      check_word("arready with a read", 32'(axi_arready), 32'd1);
      axi_arvalid <= 1'b0;
      axi_rready <= 1'b1;
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            abort_run("rvalid never rose after a read");
      end
      while (!axi_rvalid);
      check_word("read response code", 32'(axi_rresp), 32'd0);
      data = axi_rdata;
      axi_rready <= 1'b0;
   endtask

   task automatic read_check(input int index, input logic [31:0] exp, input string what);
      logic [31:0] got;
      axi_read(index, got);
      check_word($sformatf("%s (reg %0d)", what, index), got, exp);
   endtask

   function automatic int piece_worth(logic [2:0] kind);
      case (kind)
         3'd1: return `VAL_PAWN;
         3'd2: return `VAL_KNIGHT;
         3'd3: return `VAL_BISHOP;
         3'd4: return `VAL_ROOK;
         3'd5: return `VAL_QUEEN;
         default: return 0;                  // Empty square or king
      endcase
   endfunction

   function automatic int material(logic [255:0] bd);
      int         total;
      logic [3:0] p;
      total = 0;
      for (int s = 0; s < 64; s++)
      begin
         p = bd[s*4 +: 4];
         total = p[3] ? total - piece_worth(p[2:0]) : total + piece_worth(p[2:0]);
      end
      return total;
   endfunction

   function automatic logic [63:0] mark(logic [63:0] m, int r, int c);
      if (r >= 0 && r <= 7 && c >= 0 && c <= 7)
         m[r*8 + c] = 1'b1;
      return m;
   endfunction

   function automatic logic [63:0] side_attacks(logic [255:0] bd, logic black);
      logic [63:0] m;
      logic [3:0]  p;
      int          r;
      int          c;
      int          up;
      m = '0;
      up = black ? -1 : 1;
      for (int s = 0; s < 64; s++)
      begin
         p = bd[s*4 +: 4];
         r = s / 8;
         c = s % 8;
         if (p[3] == black && p[2:0] == 3'd1)
            m = mark(mark(m, r + up, c - 1), r + up, c + 1);
         if (p[3] == black && p[2:0] == 3'd2)
         begin
            m = mark(mark(m, r + 2, c + 1), r + 2, c - 1);
            m = mark(mark(m, r - 2, c + 1), r - 2, c - 1);
            m = mark(mark(m, r + 1, c + 2), r + 1, c - 2);
            m = mark(mark(m, r - 1, c + 2), r - 1, c - 2);
         end
         if (p[3] == black && p[2:0] == 3'd6)
         begin
            m = mark(mark(mark(m, r + 1, c - 1), r + 1, c), r + 1, c + 1);
            m = mark(mark(m, r, c - 1), r, c + 1);
            m = mark(mark(mark(m, r - 1, c - 1), r - 1, c), r - 1, c + 1);
         end
      end
      return m;
   endfunction

   function automatic logic [63:0] king_squares(logic [255:0] bd, logic black);
      logic [63:0] m;
      m = '0;
      for (int s = 0; s < 64; s++)
         if (bd[s*4 +: 4] == {black, 3'd6})
            m[s] = 1'b1;
      return m;
   endfunction

   // Knights in corners and on the h file, pawns on the a and h files
   function automatic logic [255:0] edge_board();
      logic [255:0] bd;
      bd = '0;
      bd[0*4 +: 4] = 4'h2;                   // a1 white knight
      bd[7*4 +: 4] = 4'h6;                   // h1 white king
      bd[15*4 +: 4] = 4'h1;                  // h2 white pawn
      bd[31*4 +: 4] = 4'h2;                  // h4 white knight
      bd[48*4 +: 4] = 4'h9;                  // a7 black pawn
      bd[56*4 +: 4] = 4'he;                  // a8 black king
      bd[63*4 +: 4] = 4'ha;                  // h8 black knight
      bd[39*4 +: 4] = 4'h9;                  // h5 black pawn
      return bd;
   endfunction

   function automatic logic [255:0] random_board();
      logic [255:0] bd;
      int           wk;
      int           bk;
      int           placed;
      logic [2:0]   kind;
      bd = '0;
      wk = $urandom_range(0, 63);
      do
         bk = $urandom_range(0, 63);
      while (bk == wk);
      bd[wk*4 +: 4] = 4'h6;
      bd[bk*4 +: 4] = 4'he;
      placed = 0;
      for (int s = 0; s < 64; s++)
         if (s != wk && s != bk && placed < 20 && $urandom_range(0, 3) == 0)
         begin
            kind = 3'($urandom_range(1, 5));
            if (kind == 3'd1 && (s < 8 || s >= 56))
               kind = 3'd2;                  // No pawns on the back ranks
            bd[s*4 +: 4] = {1'($urandom_range(0, 1)), kind};
            placed++;
         end
      return bd;
   endfunction

   task automatic load_board(input logic [255:0] bd);
      for (int r = 0; r < 8; r++)
         axi_write(`REG_BOARD0 + r, bd[r*32 +: 32], 0);
      axi_write(`REG_FLAGS, $urandom(), 0);
      axi_write(`REG_HALF_MOVE, $urandom(), 0);
   endtask

   task automatic clear_valid();
      axi_write(`REG_CTRL, 32'h8000_0000, 0);
      axi_write(`REG_CTRL, 32'h0000_0000, 0);
   endtask

   task automatic wait_analysis();
      logic [31:0] ctrl;
      int          polls;
      ctrl = '0;
      polls = 0;
      while (!ctrl[2])
      begin
         if (polls == POLL_LIMIT)
            abort_run("analysis_valid never set after a start");
         axi_read(`REG_CTRL, ctrl);
         polls++;
      end
   endtask

   task automatic run_board(input logic [255:0] bd);
      clear_valid();
      load_board(bd);
      axi_write(`REG_CTRL, 32'h1, 0);
      wait_analysis();
   endtask

   task automatic attack_check(input logic [255:0] bd);
      logic [63:0] w;
      logic [63:0] b;
      w = side_attacks(bd, 1'b0);
      b = side_attacks(bd, 1'b1);
      read_check(`REG_WATK_LO, w[31:0], "white attacks low");
      read_check(`REG_WATK_LO + 1, w[63:32], "white attacks high");
      read_check(`REG_BATK_LO, b[31:0], "black attacks low");
      read_check(`REG_BATK_LO + 1, b[63:32], "black attacks high");
      read_check(`REG_CHECK,
                 {30'd0, |(king_squares(bd, 1'b1) & w), |(king_squares(bd, 1'b0) & b)},
                 "check flags");
   endtask

   task automatic check_reset_state();
      logic [31:0] data;
      @(posedge clk);
      check_word("awready after reset", 32'(axi_awready), 32'd1);
      check_word("wready after reset", 32'(axi_wready), 32'd1);
      check_word("bvalid after reset", 32'(axi_bvalid), 32'd0);
      check_word("rvalid after reset", 32'(axi_rvalid), 32'd0);
      read_check(`REG_CTRL, 32'd0, "control after reset");
      data = $urandom();
      axi_write(`REG_FLAGS, data, 4);        // Response held for four cycles
      read_check(`REG_FLAGS, data & 32'h1ff, "flags after held response");
      end_test("reset and bready");
   endtask

   task automatic register_readback();
      logic [31:0] data [8];
      logic [31:0] flags;
      logic [31:0] half;
      int          unused [8];
      unused = '{1, 5, 16, 64, 127, 140, 171, 1000};
      foreach (data[r])
      begin
         data[r] = $urandom();
         axi_write(`REG_BOARD0 + r, data[r], 0);
      end
      flags = $urandom();
      half = $urandom();
      axi_write(`REG_FLAGS, flags, 0);
      axi_write(`REG_HALF_MOVE, half, 0);
      foreach (data[r])
         read_check(`REG_BOARD0 + r, data[r], "board row");
      read_check(`REG_FLAGS, flags & 32'h1ff, "flags word");
      read_check(`REG_HALF_MOVE, half & 32'hff, "half-move counter");
      foreach (unused[i])
         read_check(unused[i], 32'd0, "unmapped register");
      end_test("register readback");
   endtask

   initial
   begin
      logic [255:0] later;
      void'($urandom(32'hfd83725d));
      rst = 1'b1;
      axi_araddr = '0;
      axi_arprot = '0;
      axi_arvalid = 1'b0;
      axi_awaddr = '0;
      axi_awprot = '0;
      axi_awvalid = 1'b0;
      axi_bready = 1'b0;
      axi_rready = 1'b0;
      axi_wdata = '0;
      axi_wstrb = 4'hf;
      axi_wvalid = 1'b0;
      checks = 0;
      test_errors = 0;
      total_errors = 0;
      failed_tests = 0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      check_reset_state();
      register_readback();

      boards[0] = edge_board();
      for (int i = 1; i < 10; i++)
         boards[i] = random_board();
      foreach (boards[i])
      begin
         run_board(boards[i]);
         read_check(`REG_EVAL, 32'(material(boards[i])), "material eval");
      end
      end_test("material eval");

      foreach (boards[i])
      begin
         run_board(boards[i]);
         attack_check(boards[i]);
      end
      end_test("attack maps");

      // Position rewritten right after the first start
      later = random_board();
      clear_valid();
      load_board(boards[1]);
      axi_write(`REG_CTRL, 32'h1, 0);
      load_board(later);
      wait_analysis();
      for (int r = 0; r < 8; r++)
      begin
         read_check(`REG_SNAP0 + r, boards[1][r*32 +: 32], "snapshot row");
         read_check(`REG_BOARD0 + r, later[r*32 +: 32], "rewritten board row");
      end
      read_check(`REG_EVAL, 32'(material(boards[1])), "eval of first start");
      clear_valid();
      axi_write(`REG_CTRL, 32'h1, 0);
      wait_analysis();
      read_check(`REG_EVAL, 32'(material(later)), "eval of second start");
      load_board(boards[2]);
      clear_valid();
      axi_write(`REG_CTRL, 32'h1, 0);
      wait_analysis();
      for (int r = 0; r < 8; r++)
         read_check(`REG_SNAP0 + r, boards[2][r*32 +: 32], "snapshot after restart");
      read_check(`REG_EVAL, 32'(material(boards[2])), "eval after restart");
      attack_check(boards[2]);
      end_test("snapshot");

      axi_write(`REG_CTRL, 32'h8000_0000, 0);
      read_check(`REG_CTRL, 32'h8000_0000, "control in soft reset");
      axi_write(`REG_CTRL, 32'h0, 0);
      read_check(`REG_CTRL, 32'h0, "control after soft reset");
      end_test("soft reset");

      $display("summary: %0d checks, %0d errors, %0d of 6 groups with errors",
               checks, total_errors, failed_tests);
      if (total_errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+logic
logic/vchess_pkg.sv
logic/axi4lite_write.sv
logic/control.sv
logic/material_eval.sv
logic/attack_map.sv
logic/vchess_top.sv
verif/vchess_tb.sv

// ==== Bender.yml ====
package:
  name: vchess

sources:
  - include_dirs:
      - logic
    files:
      - logic/vchess_pkg.sv
      - logic/axi4lite_write.sv
      - logic/control.sv
      - logic/material_eval.sv
      - logic/attack_map.sv
      - logic/vchess_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/vchess_tb.sv
